/* Bender.yml */
package:
  name: path_oram_backend

sources:
  - rtl/OramPkg.sv
  - rtl/DramPkg.sv
  - rtl/CipherLane.sv
  - rtl/PathController.sv
  - rtl/PathStash.sv
  - rtl/PathOramBackend.sv
  - target: test
    files:
      - verification/DramModel.sv
      - verification/PathOramBackendTb.sv

/* src.f */
rtl/OramPkg.sv
rtl/DramPkg.sv
rtl/CipherLane.sv
rtl/PathController.sv
rtl/PathStash.sv
rtl/PathOramBackend.sv
verification/DramModel.sv
verification/PathOramBackendTb.sv

/* verification/PathOramBackendTb.sv */
//----------------------------------------
// Testbench for the Path ORAM backend
// Directed tests, reference model, watchdog
//----------------------------------------
module PathOramBackendTb;
	timeunit 1ns;
	timeprecision 10ps;
	import OramPkg::*;
	import DramPkg::*;

	localparam int OramL = 3;
	localparam int OramZ = 2;
	localparam int TreeWords = ((2 << OramL) - 1) * OramZ;
	localparam logic [31:0] TbKey = 32'h3c71_a94e;
	localparam real ClockPeriod = 4.0;
	localparam int MixedOps = 24;
	localparam int NumAddrs = 5;

	// Init pass plus worst throttled path per command
	localparam int CommandCount = 3 + MixedOps + NumAddrs;
	localparam int PathCycles = 150;
	localparam int WatchdogCycles = TreeWords * 8 + CommandCount * PathCycles + 100;

	logic Clock;
	logic rstN;
	OramCmd Command;
	logic [BlockAddr-1:0] PAddr;
	logic [MaxLeafWidth-1:0] CurrentLeaf;
	logic [MaxLeafWidth-1:0] RemappedLeaf;
	logic CommandValid;
	logic CommandReady;
	logic [BlockData-1:0] LoadData;
	logic LoadValid;
	logic LoadReady;
	logic [BlockData-1:0] StoreData;
	logic StoreValid;
	logic StoreReady;
	logic [DramAddr-1:0] DRAMCommandAddress;
	DramCmd DRAMCommand;
	logic DRAMCommandValid;
	logic DRAMCommandReady;
	logic [DramWord-1:0] DRAMReadData;
	logic DRAMReadDataValid;
	logic DRAMReadDataReady;
	logic [DramWord-1:0] DRAMWriteData;
	logic DRAMWriteDataValid;
	logic DRAMWriteDataReady;

	// DRAM model control and write reports
	logic Throttle;
	logic WriteSeen;
	logic [DramAddr-1:0] WriteAddr;
	logic [DramWord-1:0] WriteWord;

	//----------------------------------------
	// Reference model
	//----------------------------------------
	logic [BlockData-1:0] RefData [256];
	logic [OramL-1:0] PosMap [256];
	// Leaf of the path the current command works on
	logic [OramL-1:0] CmdLeaf;
	logic [TreeWords-1:0] InitSeen;
	logic InitPhase;
	logic [31:0] Rng;
	int ValueErrors;
	int ProtocolErrors;

	PathOramBackend #(
		.OramL(OramL),
		.OramZ(OramZ),
		.StashSize(16),
		.CipherKey(TbKey)
	) PathOramBackend_i (.*);

	DramModel #(
		.Seed(32'd90)
	) DramModel_i (.*);

	always #(ClockPeriod / 2) Clock = ~Clock;

	function automatic logic [31:0] xorshiftStep(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// Counter-mode pad, one 16-bit slice per lane
	function automatic logic [DramWord-1:0] padWord(input logic [DramAddr-1:0] addr);
		logic [31:0] x;
		logic [DramWord-1:0] pad;
		pad = '0;
		for (int lane = 0; lane < NumLanes; lane++) begin
			x = {16'h0, addr} ^ TbKey ^ (32'(lane) << 16);
			x = x ^ (x << 13);
			x = x ^ (x >> 17);
			x = x ^ (x << 5);
			pad[lane*LaneWidth +: LaneWidth] = x[LaneWidth-1:0];
		end
		return pad;
	endfunction

	// Heap index of the bucket at this level on the path to leaf
	function automatic int pathBucket(input logic [OramL-1:0] leaf, input int level);
		return (1 << level) - 1 + int'(leaf >> (OramL - level));
	endfunction

	task automatic wrongValue(input string msg);
		ValueErrors++;
		$display("** Error @ %0t ns: %s", $time, msg);
	endtask

	task automatic protocolFault(input string msg);
		ProtocolErrors++;
		$display("Protocol fault at %0t ns: %s", $time, msg);
	endtask

	//----------------------------------------
	// DRAM write monitor
	//----------------------------------------
	task automatic inspectWrite(input logic [DramAddr-1:0] addr, input logic [DramWord-1:0] word);
		logic [DramWord-1:0] plain;
		logic [BlockAddr-1:0] blockAddr;
		logic [MaxLeafWidth-1:0] blockLeaf;
		int bucket;
		int level;
		plain = word ^ padWord(addr);
		bucket = int'(addr) / OramZ;
		level = 0;
		while (bucket >= (2 << level) - 1)
			level++;
		assert (int'(addr) < TreeWords)
			else protocolFault($sformatf("write to %0d lies outside the tree", addr));
		if (InitPhase) begin
			// Init pass stores encrypted empty blocks
			assert (plain == '0)
				else wrongValue($sformatf("init word %0d decrypts to %h", addr, plain));
			if (int'(addr) < TreeWords)
				InitSeen[addr] = 1'b1;
		end else begin
			assert (bucket == pathBucket(CmdLeaf, level))
				else protocolFault($sformatf("eviction wrote bucket %0d, off the path", bucket));
			if (plain[ValidPos]) begin
				blockAddr = plain[AddrLsb +: BlockAddr];
				blockLeaf = plain[LeafLsb +: MaxLeafWidth];
				assert (bucket == pathBucket(blockLeaf[OramL-1:0], level))
					else wrongValue($sformatf("block %h leaf %0d not on bucket %0d",
						blockAddr, blockLeaf, bucket));
				assert (blockLeaf == MaxLeafWidth'(PosMap[blockAddr]))
					else wrongValue($sformatf("block %h leaf %0d, expected %0d",
						blockAddr, blockLeaf, PosMap[blockAddr]));
				assert (plain[DataLsb +: BlockData] == RefData[blockAddr])
					else wrongValue($sformatf("block %h evicted data %h, expected %h",
						blockAddr, plain[DataLsb +: BlockData], RefData[blockAddr]));
			end else begin
				assert (plain == '0)
					else wrongValue($sformatf("empty block at %0d decrypts to %h", addr, plain));
			end
		end
	endtask

	// Report registered on the rising edge, read on the falling one
	always @(negedge Clock) begin
		if (WriteSeen)
			inspectWrite(WriteAddr, WriteWord);
	end

	//----------------------------------------
	// Frontend drivers
	//----------------------------------------
	task automatic sendCommand(input OramCmd cmd, input logic [BlockAddr-1:0] addr,
			input logic [OramL-1:0] newLeaf);
		while (!CommandReady)
			@(negedge Clock);
		CmdLeaf = PosMap[addr];
		Command = cmd;
		PAddr = addr;
		CurrentLeaf = MaxLeafWidth'(PosMap[addr]);
		RemappedLeaf = MaxLeafWidth'(newLeaf);
		CommandValid = 1'b1;
		PosMap[addr] = newLeaf;
		@(negedge Clock);
		CommandValid = 1'b0;
		assert (!CommandReady)
			else protocolFault("command was not taken while CommandReady was high");
	endtask

	task automatic readBlock(input logic [BlockAddr-1:0] addr, input logic [OramL-1:0] newLeaf,
			input int holdCycles);
		logic [BlockData-1:0] held;
		sendCommand(CmdRead, addr, newLeaf);
		while (!LoadValid) begin
			assert (!StoreReady) else protocolFault("StoreReady raised during a read");
			@(negedge Clock);
		end
		held = LoadData;
		// LoadReady low, the load must stay put
		repeat (holdCycles) begin
			@(negedge Clock);
			assert (LoadValid) else protocolFault("LoadValid dropped before LoadReady");
			assert (LoadData == held)
				else wrongValue($sformatf("LoadData moved from %h to %h while stalled",
					held, LoadData));
		end
		assert (held == RefData[addr])
			else wrongValue($sformatf("read of %h returned %h, expected %h",
				addr, held, RefData[addr]));
		LoadReady = 1'b1;
		@(negedge Clock);
		LoadReady = 1'b0;
		assert (!LoadValid) else protocolFault("LoadValid still high after the handshake");
	endtask

	task automatic writeBlock(input logic [BlockAddr-1:0] addr, input logic [OramL-1:0] newLeaf,
			input logic [BlockData-1:0] data);
		sendCommand(CmdWrite, addr, newLeaf);
		RefData[addr] = data;
		while (!StoreReady) begin
			assert (!LoadValid) else protocolFault("a write command produced a load");
			@(negedge Clock);
		end
		StoreData = data;
		StoreValid = 1'b1;
		@(negedge Clock);
		StoreValid = 1'b0;
		assert (!StoreReady) else protocolFault("StoreReady still high after the handshake");
	endtask

	//----------------------------------------
	// Directed tests
	//----------------------------------------
	task automatic checkInitPass();
		// Ready only after every tree word went out
		while (!CommandReady)
			@(negedge Clock);
		assert (InitSeen == '1)
			else protocolFault($sformatf("CommandReady rose with %0d of %0d tree words written",
				$countones(InitSeen), TreeWords));
		InitPhase = 1'b0;
	endtask

	task automatic readUntouched();
		Throttle = 1'b0;
		readBlock(8'h5c, 3'd6, 2);
	endtask

	task automatic writeThenRead();
		Throttle = 1'b1;
		writeBlock(8'h22, 3'd1, 32'hcafe_f00d);
		readBlock(8'h22, 3'd4, 3);
	endtask

	task automatic mixedTraffic();
		logic [BlockAddr-1:0] addrs [NumAddrs];
		logic [BlockAddr-1:0] addr;
		addrs = '{8'h03, 8'h22, 8'h5c, 8'h80, 8'hff};
		for (int i = 0; i < MixedOps; i++) begin
			Rng = xorshiftStep(Rng);
			addr = addrs[Rng[7:0] % NumAddrs];
			if (Rng[8])
				writeBlock(addr, Rng[15:13], xorshiftStep(Rng ^ 32'h9e37_79b9));
			else
				readBlock(addr, Rng[15:13], int'(Rng[11:10]));
		end
		// Final sweep over every address
		for (int i = 0; i < NumAddrs; i++) begin
			Rng = xorshiftStep(Rng);
			readBlock(addrs[i], Rng[2:0], 1);
		end
	endtask

	initial begin
		Clock = 1'b0;
		rstN = 1'b0;
		Command = CmdRead;
		PAddr = '0;
		CurrentLeaf = '0;
		RemappedLeaf = '0;
		CommandValid = 1'b0;
		LoadReady = 1'b0;
		StoreData = '0;
		StoreValid = 1'b0;
		Throttle = 1'b1;
		InitPhase = 1'b1;
		InitSeen = '0;
		CmdLeaf = '0;
		Rng = 32'd90;
		ValueErrors = 0;
		ProtocolErrors = 0;
		for (int i = 0; i < 256; i++) begin
			RefData[i] = '0;
			PosMap[i] = OramL'(i);
		end
		repeat (2) @(negedge Clock);
		rstN = 1'b1;

		checkInitPass();
		readUntouched();
		writeThenRead();
		mixedTraffic();

		$display("Errors: %0d wrong values, %0d protocol faults", ValueErrors, ProtocolErrors);
		if (ValueErrors == 0 && ProtocolErrors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		#(WatchdogCycles * ClockPeriod);
		$display("Timeout: tests did not finish within %0d cycles (%0d value, %0d protocol errors)",
			WatchdogCycles, ValueErrors, ProtocolErrors);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

/* verification/DramModel.sv */
//----------------------------------------
// Behavioral DRAM holding ciphertext only
// Random back-pressure from an xorshift
//----------------------------------------
module DramModel #(
	parameter logic [31:0] Seed = 32'd90,
	parameter int Depth = 64
) (
	input  logic Clock,
	input  logic rstN,
	input  logic Throttle,
	input  logic [DramPkg::DramAddr-1:0] DRAMCommandAddress,
	input  DramPkg::DramCmd DRAMCommand,
	input  logic DRAMCommandValid,
	output logic DRAMCommandReady,
	output logic [DramPkg::DramWord-1:0] DRAMReadData,
	output logic DRAMReadDataValid,
	input  logic DRAMReadDataReady,
	input  logic [DramPkg::DramWord-1:0] DRAMWriteData,
	input  logic DRAMWriteDataValid,
	output logic DRAMWriteDataReady,
	output logic WriteSeen,
	output logic [DramPkg::DramAddr-1:0] WriteAddr,
	output logic [DramPkg::DramWord-1:0] WriteWord
);
	timeunit 1ns;
	timeprecision 10ps;
	import DramPkg::*;

	logic [DramWord-1:0] Mem [Depth];

	// Pending reads, and write commands waiting for their data
	logic [DramAddr-1:0] ReadQ [$];
	logic [DramAddr-1:0] WrAddrQ [$];
	logic [DramWord-1:0] WrDataQ [$];

	logic [31:0] Rng;
	logic ThrottleQ;
	logic Active;

	function automatic logic [31:0] xorshiftStep(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	initial begin
		// Fill pattern depends on the full address
		for (int i = 0; i < Depth; i++)
			Mem[i] = {32'hdead_beef ^ 32'(i), 32'(i) * 32'h0101_0101};
		Rng = Seed;
		ThrottleQ = 1'b0;
		Active = 1'b0;
		DRAMCommandReady = 1'b0;
		DRAMWriteDataReady = 1'b0;
		DRAMReadDataValid = 1'b0;
		DRAMReadData = '0;
		WriteSeen = 1'b0;
		WriteAddr = '0;
		WriteWord = '0;
	end

	//----------------------------------------
	// Handshakes taken on the rising edge
	//----------------------------------------
	always @(posedge Clock) begin
		WriteSeen <= 1'b0;
		ThrottleQ <= Throttle;
		Active <= rstN;
		if (!rstN) begin
			ReadQ.delete();
			WrAddrQ.delete();
			WrDataQ.delete();
		end else begin
			if (DRAMReadDataValid && DRAMReadDataReady)
				void'(ReadQ.pop_front());
			if (DRAMCommandValid && DRAMCommandReady) begin
				if (DRAMCommand == DramRead)
					ReadQ.push_back(DRAMCommandAddress);
				else
					WrAddrQ.push_back(DRAMCommandAddress);
			end
			if (DRAMWriteDataValid && DRAMWriteDataReady)
				WrDataQ.push_back(DRAMWriteData);
			// One command pairs with one data word
			if (WrAddrQ.size() > 0 && WrDataQ.size() > 0) begin
				Mem[WrAddrQ[0] % Depth] = WrDataQ[0];
				WriteAddr <= WrAddrQ[0];
				WriteWord <= WrDataQ[0];
				WriteSeen <= 1'b1;
				void'(WrAddrQ.pop_front());
				void'(WrDataQ.pop_front());
			end
		end
	end

	// Outputs change on the falling edge, roughly 3 in 4 cycles ready
	always @(negedge Clock) begin
		Rng = xorshiftStep(Rng);
		DRAMCommandReady = Active && (!ThrottleQ || Rng[1:0] != 2'b00);
		DRAMWriteDataReady = Active && (!ThrottleQ || Rng[3:2] != 2'b00);
		DRAMReadDataValid = Active && ReadQ.size() > 0 && (!ThrottleQ || Rng[5:4] != 2'b00);
		// Read data returns in command order
		DRAMReadData = (ReadQ.size() > 0) ? Mem[ReadQ[0] % Depth] : '0;
	end

endmodule

/* rtl/PathOramBackend.sv */
//----------------------------------------
// Path ORAM backend top level
// Controller, cipher lanes and stash
//----------------------------------------
module PathOramBackend #(
	parameter int OramL = 3,
	parameter int OramZ = 2,
	parameter int StashSize = 16,
	parameter logic [31:0] CipherKey = 32'h5a3c_96e1
) (
	input  logic Clock,
	input  logic rstN,

	// Frontend
	input  OramPkg::OramCmd Command,
	input  logic [OramPkg::BlockAddr-1:0] PAddr,
	input  logic [OramPkg::MaxLeafWidth-1:0] CurrentLeaf,
	input  logic [OramPkg::MaxLeafWidth-1:0] RemappedLeaf,
	input  logic CommandValid,
	output logic CommandReady,
	output logic [OramPkg::BlockData-1:0] LoadData,
	output logic LoadValid,
	input  logic LoadReady,
	input  logic [OramPkg::BlockData-1:0] StoreData,
	input  logic StoreValid,
	output logic StoreReady,

	// DRAM
	output logic [DramPkg::DramAddr-1:0] DRAMCommandAddress,
	output DramPkg::DramCmd DRAMCommand,
	output logic DRAMCommandValid,
	input  logic DRAMCommandReady,
	input  logic [DramPkg::DramWord-1:0] DRAMReadData,
	input  logic DRAMReadDataValid,
	output logic DRAMReadDataReady,
	output logic [DramPkg::DramWord-1:0] DRAMWriteData,
	output logic DRAMWriteDataValid,
	input  logic DRAMWriteDataReady
);
	import OramPkg::*;
	import DramPkg::*;

	localparam int LevelW = $clog2(OramL + 2);

	//----------------------------------------
	// Internal wiring
	//----------------------------------------
	// Controller to lanes
	logic [DramWord-1:0] LaneData;
	logic [DramAddr-1:0] LaneAddr;
	logic LaneValid;
	logic LaneAdvance;

	// Lanes back out
	logic [NumLanes-1:0] LaneOutValid;
	logic [DramWord-1:0] CipherWord;

	// Controller and stash
	logic ReadWordValid;
	logic ServeStart;
	logic ServeDone;
	logic [DramWord-1:0] EvictWord;
	logic EvictValid;
	logic [LevelW-1:0] EvictLevel;
	logic EvictTake;
	OramCmd LatchedCmd;
	logic [BlockAddr-1:0] LatchedAddr;
	logic [MaxLeafWidth-1:0] LatchedLeaf;
	logic [MaxLeafWidth-1:0] LatchedRemap;

	// Encrypted eviction words go straight out
	assign DRAMWriteData = CipherWord;

	PathController #(
		.OramL(OramL),
		.OramZ(OramZ)
	) PathController_i (
		.Clock(Clock),
		.rstN(rstN),
		.Command(Command),
		.PAddr(PAddr),
		.CurrentLeaf(CurrentLeaf),
		.RemappedLeaf(RemappedLeaf),
		.CommandValid(CommandValid),
		.CommandReady(CommandReady),
		.DRAMCommandAddress(DRAMCommandAddress),
		.DRAMCommand(DRAMCommand),
		.DRAMCommandValid(DRAMCommandValid),
		.DRAMCommandReady(DRAMCommandReady),
		.DRAMReadData(DRAMReadData),
		.DRAMReadDataValid(DRAMReadDataValid),
		.DRAMReadDataReady(DRAMReadDataReady),
		.DRAMWriteDataValid(DRAMWriteDataValid),
		.DRAMWriteDataReady(DRAMWriteDataReady),
		.LaneData(LaneData),
		.LaneAddr(LaneAddr),
		.LaneValid(LaneValid),
		.LaneAdvance(LaneAdvance),
		.LaneOutValid(LaneOutValid),
		.ReadWordValid(ReadWordValid),
		.ServeStart(ServeStart),
		.ServeDone(ServeDone),
		.EvictWord(EvictWord),
		.EvictValid(EvictValid),
		.EvictLevel(EvictLevel),
		.EvictTake(EvictTake),
		.LatchedCmd(LatchedCmd),
		.LatchedAddr(LatchedAddr),
		.LatchedLeaf(LatchedLeaf),
		.LatchedRemap(LatchedRemap)
	);

	// One lane per 16-bit slice
	for (genvar g = 0; g < NumLanes; g++) begin : genLane
		CipherLane #(
			.CipherKey(CipherKey),
			.LaneIndex(g)
		) CipherLane_i (
			.Clock(Clock),
			.rstN(rstN),
			.LaneData(LaneData[g*LaneWidth +: LaneWidth]),
			.LaneAddr(LaneAddr),
			.LaneValid(LaneValid),
			.LaneAdvance(LaneAdvance),
			.LaneOut(CipherWord[g*LaneWidth +: LaneWidth]),
			.LaneOutValid(LaneOutValid[g])
		);
	end

	PathStash #(
		.OramL(OramL),
		.OramZ(OramZ),
		.StashSize(StashSize)
	) PathStash_i (
		.Clock(Clock),
		.rstN(rstN),
		.CipherWord(CipherWord),
		.ReadWordValid(ReadWordValid),
		.ServeStart(ServeStart),
		.LatchedCmd(LatchedCmd),
		.LatchedAddr(LatchedAddr),
		.LatchedLeaf(LatchedLeaf),
		.LatchedRemap(LatchedRemap),
		.StoreData(StoreData),
		.StoreValid(StoreValid),
		.LoadReady(LoadReady),
		.EvictLevel(EvictLevel),
		.EvictTake(EvictTake),
		.LoadData(LoadData),
		.LoadValid(LoadValid),
		.StoreReady(StoreReady),
		.ServeDone(ServeDone),
		.EvictWord(EvictWord),
		.EvictValid(EvictValid)
	);

endmodule

/* rtl/PathStash.sv */
//----------------------------------------
// Stash block store with load and store
// service and eviction selection per bucket
//----------------------------------------
module PathStash #(
	parameter int OramL = 3,
	parameter int OramZ = 2,
	parameter int StashSize = 16
) (
	input  logic Clock,
	input  logic rstN,
	input  logic [DramPkg::DramWord-1:0] CipherWord,
	input  logic ReadWordValid,
	input  logic ServeStart,
	input  OramPkg::OramCmd LatchedCmd,
	input  logic [OramPkg::BlockAddr-1:0] LatchedAddr,
	input  logic [OramPkg::MaxLeafWidth-1:0] LatchedLeaf,
	input  logic [OramPkg::MaxLeafWidth-1:0] LatchedRemap,
	input  logic [OramPkg::BlockData-1:0] StoreData,
	input  logic StoreValid,
	input  logic LoadReady,
	input  logic [$clog2(OramL + 2)-1:0] EvictLevel,
	input  logic EvictTake,
	output logic [OramPkg::BlockData-1:0] LoadData,
	output logic LoadValid,
	output logic StoreReady,
	output logic ServeDone,
	output logic [DramPkg::DramWord-1:0] EvictWord,
	output logic EvictValid
);
	import OramPkg::*;
	import DramPkg::*;

	localparam int IdxW = $clog2(StashSize);

	//----------------------------------------
	// Entry storage
	//----------------------------------------
	logic [StashSize-1:0] EntValid;
	logic [BlockAddr-1:0] EntAddr [StashSize];
	logic [MaxLeafWidth-1:0] EntLeaf [StashSize];
	logic [BlockData-1:0] EntData [StashSize];

	// Search results
	logic [IdxW-1:0] FreeIdx, HitIdx, EvIdx, ServeIdx, NewIdx;
	logic Hit, EvFit;
	logic [OramL-1:0] LeafDiff;

	// Lowest matching index wins
	always_comb begin
		FreeIdx = '0;
		HitIdx = '0;
		Hit = 1'b0;
		EvIdx = '0;
		EvFit = 1'b0;
		LeafDiff = '0;
		for (int i = StashSize - 1; i >= 0; i--) begin
			if (!EntValid[i])
				FreeIdx = IdxW'(i);
			if (EntValid[i] && EntAddr[i] == LatchedAddr) begin
				HitIdx = IdxW'(i);
				Hit = 1'b1;
			end
			// Same path prefix down to the offered level
			LeafDiff = (EntLeaf[i][OramL-1:0] ^ LatchedLeaf[OramL-1:0])
				>> (OramL - int'(EvictLevel));
			if (EntValid[i] && LeafDiff == '0) begin
				EvIdx = IdxW'(i);
				EvFit = 1'b1;
			end
		end
	end

	assign NewIdx = Hit ? HitIdx : FreeIdx;

	// Empty block when nothing fits
	assign EvictWord = EvFit
		? DramWord'({EntData[EvIdx], EntLeaf[EvIdx], EntAddr[EvIdx], 1'b1}) : '0;

	// No offers while a request is being served
	assign EvictValid = !LoadValid && !StoreReady;

	assign ServeDone = (LoadValid && LoadReady) || (StoreReady && StoreValid);

	//----------------------------------------
	// Control state
	//----------------------------------------
	always_ff @(posedge Clock) begin
		if (!rstN) begin
			EntValid <= '0;
			LoadValid <= 1'b0;
			StoreReady <= 1'b0;
		end else begin
			// Real blocks from the path read
			if (ReadWordValid && CipherWord[ValidPos])
				EntValid[FreeIdx] <= 1'b1;

			if (ServeStart) begin
				EntValid[NewIdx] <= 1'b1;
				if (LatchedCmd == CmdRead)
					LoadValid <= 1'b1;
				else
					StoreReady <= 1'b1;
			end

			if (LoadValid && LoadReady)
				LoadValid <= 1'b0;
			if (StoreReady && StoreValid)
				StoreReady <= 1'b0;

			if (EvictTake && EvFit)
				EntValid[EvIdx] <= 1'b0;
		end
	end

	//----------------------------------------
	// Payload
	//----------------------------------------
	always_ff @(posedge Clock) begin
		if (ReadWordValid && CipherWord[ValidPos]) begin
			EntAddr[FreeIdx] <= CipherWord[AddrLsb +: BlockAddr];
			EntLeaf[FreeIdx] <= CipherWord[LeafLsb +: MaxLeafWidth];
			EntData[FreeIdx] <= CipherWord[DataLsb +: BlockData];
		end

		if (ServeStart) begin
			ServeIdx <= NewIdx;
			EntAddr[NewIdx] <= LatchedAddr;
			// Block moves to its remapped leaf
			EntLeaf[NewIdx] <= LatchedRemap;
			// Absent block reads as zero
			if (!Hit)
				EntData[NewIdx] <= '0;
			LoadData <= Hit ? EntData[HitIdx] : '0;
		end

		if (StoreReady && StoreValid)
			EntData[ServeIdx] <= StoreData;
	end

endmodule

/* rtl/PathController.sv */
//----------------------------------------
// Path controller: init pass, path
// addresses, phase FSM, lane steering
//----------------------------------------
module PathController #(
	parameter int OramL = 3,
	parameter int OramZ = 2
) (
	input  logic Clock,
	input  logic rstN,
	input  OramPkg::OramCmd Command,
	input  logic [OramPkg::BlockAddr-1:0] PAddr,
	input  logic [OramPkg::MaxLeafWidth-1:0] CurrentLeaf,
	input  logic [OramPkg::MaxLeafWidth-1:0] RemappedLeaf,
	input  logic CommandValid,
	output logic CommandReady,
	output logic [DramPkg::DramAddr-1:0] DRAMCommandAddress,
	output DramPkg::DramCmd DRAMCommand,
	output logic DRAMCommandValid,
	input  logic DRAMCommandReady,
	input  logic [DramPkg::DramWord-1:0] DRAMReadData,
	input  logic DRAMReadDataValid,
	output logic DRAMReadDataReady,
	output logic DRAMWriteDataValid,
	input  logic DRAMWriteDataReady,
	output logic [DramPkg::DramWord-1:0] LaneData,
	output logic [DramPkg::DramAddr-1:0] LaneAddr,
	output logic LaneValid,
	output logic LaneAdvance,
	input  logic [DramPkg::NumLanes-1:0] LaneOutValid,
	output logic ReadWordValid,
	output logic ServeStart,
	input  logic ServeDone,
	input  logic [DramPkg::DramWord-1:0] EvictWord,
	input  logic EvictValid,
	output logic [$clog2(OramL + 2)-1:0] EvictLevel,
	output logic EvictTake,
	output OramPkg::OramCmd LatchedCmd,
	output logic [OramPkg::BlockAddr-1:0] LatchedAddr,
	output logic [OramPkg::MaxLeafWidth-1:0] LatchedLeaf,
	output logic [OramPkg::MaxLeafWidth-1:0] LatchedRemap
);
	import OramPkg::*;
	import DramPkg::*;

	localparam int LevelW = $clog2(OramL + 2);
	localparam int SlotW = $clog2(OramZ + 1);
	localparam int PathWords = (OramL + 1) * OramZ;
	localparam int TreeWords = ((2 << OramL) - 1) * OramZ;

	PhaseState State;

	// Read issue and return positions along the path
	logic [LevelW-1:0] IssLevel, RetLevel, EvLevel;
	logic [SlotW-1:0] IssSlot, RetSlot, EvSlot;
	logic [DramAddr-1:0] FeedCnt, EvCnt, OutAddr;

	// Write-side handshake bookkeeping
	logic CmdSent, DataSent;
	logic LaneOutAll, WritePhase, WordDone, Feed;

	// Heap index of the path bucket, times Z, plus slot
	function automatic logic [DramAddr-1:0] wordAddr(input logic [LevelW-1:0] Lvl,
			input logic [SlotW-1:0] Slot, input logic [MaxLeafWidth-1:0] Leaf);
		logic [DramAddr-1:0] Idx;
		Idx = ((DramAddr'(1) << Lvl) - DramAddr'(1))
			+ (DramAddr'(Leaf[OramL-1:0]) >> (OramL - int'(Lvl)));
		return Idx * DramAddr'(OramZ) + DramAddr'(Slot);
	endfunction

	assign LaneOutAll = &LaneOutValid;
	assign WritePhase = State inside {PhInit, PhEvictCmd, PhEvictData};

	// Lane word leaves once command and data are both taken
	assign WordDone = WritePhase & LaneOutAll & (CmdSent | DRAMCommandReady)
		& (DataSent | DRAMWriteDataReady);

	// Write stall holds the lanes, reads never stall
	assign LaneAdvance = WritePhase ? (!LaneOutAll | WordDone) : 1'b1;
	assign Feed = LaneValid & LaneAdvance;

	//----------------------------------------
	// Lane input steering
	//----------------------------------------
	always_comb begin
		case (State)
			PhInit: begin
				// Zero word encrypts to an empty block
				LaneData = '0;
				LaneAddr = FeedCnt;
				LaneValid = FeedCnt != DramAddr'(TreeWords);
			end
			PhReadCmd, PhReadData: begin
				LaneData = DRAMReadData;
				LaneAddr = wordAddr(RetLevel, RetSlot, LatchedLeaf);
				LaneValid = DRAMReadDataValid;
			end
			PhEvictCmd: begin
				LaneData = EvictWord;
				LaneAddr = wordAddr(EvLevel, EvSlot, LatchedLeaf);
				LaneValid = EvictValid;
			end
			default: begin
				LaneData = '0;
				LaneAddr = OutAddr;
				LaneValid = 1'b0;
			end
		endcase
	end

	// DRAM side
	assign CommandReady = State == PhIdle;
	assign DRAMReadDataReady = State inside {PhReadCmd, PhReadData};
	assign DRAMCommandValid = (State == PhReadCmd) | (WritePhase & LaneOutAll & !CmdSent);
	assign DRAMCommand = (State == PhReadCmd) ? DramRead : DramWrite;
	assign DRAMCommandAddress = (State == PhReadCmd)
		? wordAddr(IssLevel, IssSlot, LatchedLeaf) : OutAddr;
	assign DRAMWriteDataValid = WritePhase & LaneOutAll & !DataSent;

	// Stash side
	assign ReadWordValid = LaneOutAll & DRAMReadDataReady;
	assign EvictLevel = EvLevel;
	assign EvictTake = (State == PhEvictCmd) & Feed;

	//----------------------------------------
	// Phase FSM and path counters
	//----------------------------------------
	always_ff @(posedge Clock) begin
		if (!rstN) begin
			State <= PhInit;
			FeedCnt <= '0;
			EvCnt <= '0;
			IssLevel <= '0;
			IssSlot <= '0;
			RetLevel <= '0;
			RetSlot <= '0;
			EvLevel <= '0;
			EvSlot <= '0;
			CmdSent <= 1'b0;
			DataSent <= 1'b0;
			ServeStart <= 1'b0;
		end else begin
			ServeStart <= 1'b0;

			// Flags belong to the word at the lane output
			if (LaneAdvance) begin
				CmdSent <= 1'b0;
				DataSent <= 1'b0;
			end else begin
				if (DRAMCommandValid && DRAMCommandReady)
					CmdSent <= 1'b1;
				if (DRAMWriteDataValid && DRAMWriteDataReady)
					DataSent <= 1'b1;
			end

			// Returned words walk root to leaf
			if (DRAMReadDataValid && DRAMReadDataReady) begin
				if (RetSlot == SlotW'(OramZ - 1)) begin
					RetSlot <= '0;
					RetLevel <= RetLevel + 1'b1;
				end else begin
					RetSlot <= RetSlot + 1'b1;
				end
			end

			case (State)
				PhInit: begin
					if (Feed)
						FeedCnt <= FeedCnt + 1'b1;
					if (FeedCnt == DramAddr'(TreeWords) && !LaneOutAll)
						State <= PhIdle;
				end
				PhIdle: begin
					if (CommandValid) begin
						State <= PhReadCmd;
						IssLevel <= '0;
						IssSlot <= '0;
						RetLevel <= '0;
						RetSlot <= '0;
					end
				end
				PhReadCmd: begin
					// Reads may run ahead of returned data
					if (DRAMCommandReady) begin
						if (IssSlot == SlotW'(OramZ - 1)) begin
							IssSlot <= '0;
							IssLevel <= IssLevel + 1'b1;
							if (IssLevel == LevelW'(OramL))
								State <= PhReadData;
						end else begin
							IssSlot <= IssSlot + 1'b1;
						end
					end
				end
				PhReadData: begin
					// Whole path back and lanes drained
					if (RetLevel == LevelW'(OramL + 1) && !LaneOutAll) begin
						State <= PhServe;
						ServeStart <= 1'b1;
					end
				end
				PhServe: begin
					if (ServeDone) begin
						State <= PhEvictCmd;
						EvLevel <= LevelW'(OramL);
						EvSlot <= '0;
						EvCnt <= '0;
					end
				end
				PhEvictCmd: begin
					// Deepest bucket first
					if (Feed) begin
						EvCnt <= EvCnt + 1'b1;
						if (EvSlot == SlotW'(OramZ - 1)) begin
							EvSlot <= '0;
							EvLevel <= EvLevel - 1'b1;
						end else begin
							EvSlot <= EvSlot + 1'b1;
						end
						if (EvCnt == DramAddr'(PathWords - 1))
							State <= PhEvictData;
					end
				end
				PhEvictData: begin
					if (!LaneOutAll)
						State <= PhIdle;
				end
				default: State <= PhIdle;
			endcase
		end
	end

	// Address of the word now in the lanes
	always_ff @(posedge Clock) begin
		if (Feed)
			OutAddr <= LaneAddr;
	end

	// Command fields
	always_ff @(posedge Clock) begin
		if (CommandValid && CommandReady) begin
			LatchedCmd <= Command;
			LatchedAddr <= PAddr;
			LatchedLeaf <= CurrentLeaf;
			LatchedRemap <= RemappedLeaf;
		end
	end

endmodule

/* rtl/CipherLane.sv */
//----------------------------------------
// One slice of the counter-mode cipher
//----------------------------------------
module CipherLane #(
	parameter logic [31:0] CipherKey = 32'h0,
	parameter int LaneIndex = 0
) (
	input  logic Clock,
	input  logic rstN,
	input  logic [DramPkg::LaneWidth-1:0] LaneData,
	input  logic [DramPkg::DramAddr-1:0] LaneAddr,
	input  logic LaneValid,
	input  logic LaneAdvance,
	output logic [DramPkg::LaneWidth-1:0] LaneOut,
	output logic LaneOutValid
);
	import DramPkg::*;

	logic [31:0] Seed;
	logic [31:0] Mix;
	logic [LaneWidth-1:0] Pad;

	// Address and key, lane index in the upper half
	assign Seed = (32'(LaneAddr) ^ CipherKey) ^ (32'(LaneIndex) << 16);

	// One xorshift round
	always_comb begin
		Mix = Seed;
		Mix = Mix ^ (Mix << 13);
		Mix = Mix ^ (Mix >> 17);
		Mix = Mix ^ (Mix << 5);
	end

	assign Pad = Mix[LaneWidth-1:0];

	// Output held while stalled
	always_ff @(posedge Clock) begin
		if (!rstN) begin
			LaneOutValid <= 1'b0;
		end else if (LaneAdvance) begin
			LaneOutValid <= LaneValid;
		end
	end

	// Same XOR encrypts and decrypts
	always_ff @(posedge Clock) begin
		if (LaneAdvance) begin
			LaneOut <= LaneData ^ Pad;
		end
	end

endmodule

/* rtl/DramPkg.sv */
//----------------------------------------
// DRAM word and address widths, DRAM
// commands and the cipher lane split
//----------------------------------------
package DramPkg;

	// One block per DRAM word
	localparam int DramWord = 64;

	// Bucket word address
	localparam int DramAddr = 16;

	// Slice handled by a single cipher lane
	localparam int LaneWidth = 16;
	localparam int NumLanes = DramWord / LaneWidth;

	// DRAM commands
	typedef enum logic {
		DramRead,
		DramWrite
	} DramCmd;

endpackage

/* rtl/OramPkg.sv */
//----------------------------------------
// Tree geometry widths, block word layout
// and the frontend and controller enums
//----------------------------------------
package OramPkg;

	// Frontend data and address widths
	localparam int BlockData = 32;
	localparam int BlockAddr = 8;

	// Widest leaf the word layout can carry
	localparam int MaxLeafWidth = 8;

	//----------------------------------------
	// Block word layout, LSB first
	//----------------------------------------
	// Valid bit marks a real block
	localparam int ValidPos = 0;
	localparam int AddrLsb = ValidPos + 1;
	localparam int LeafLsb = AddrLsb + BlockAddr;
	localparam int DataLsb = LeafLsb + MaxLeafWidth;
	localparam int BlockWordWidth = DataLsb + BlockData;

	// Frontend commands
	typedef enum logic {
		CmdRead,
		CmdWrite
	} OramCmd;

	// Path controller phases
	typedef enum logic [2:0] {
		PhInit,
		PhIdle,
		PhReadCmd,
		PhReadData,
		PhServe,
		PhEvictCmd,
		PhEvictData
	} PhaseState;

endpackage
